// File: verilog.f
src/riscv_pkg.sv
src/lsu_if.sv
src/stage_mem1.sv
src/data_lsu.sv
src/stage_mem2.sv
src/csr_file.sv
src/mem_subsystem_top.sv
verification/mem_subsystem_sva.sv
verification/tb_mem_subsystem.sv

// File: verification/tb_mem_subsystem.sv
// memory subsystem testbench: table of operations checked against a byte reference memory
`timescale 1ns/1ns

module tb_mem_subsystem;

    localparam int MEM_WORDS   = 256;
    localparam int LSU_LATENCY = 2;

    typedef struct {
        riscv_pkg::mem_oper_t  op;
        riscv_pkg::word_t      addr;
        riscv_pkg::word_t      sdata;
        logic                  csr_we;
        riscv_pkg::csr_addr_t  caddr;
        riscv_pkg::word_t      cdata;
        riscv_pkg::exc_t       trap;
        logic                  wrd;
        riscv_pkg::reg_addr_t  rd;
        logic                  flush;
    } entry_t;

    typedef struct {
        riscv_pkg::mem_oper_t  op;
        riscv_pkg::exc_t       trap;
        logic                  wrd;
        riscv_pkg::reg_addr_t  rd;
        riscv_pkg::word_t      addr;
        riscv_pkg::word_t      data;
        int                    edge_at;
    } expect_t;

    logic clk_i;
    logic rst_i;
    logic valid_i;
    logic flush_i;
    riscv_pkg::word_t      alu_result_i;
    riscv_pkg::word_t      store_data_i;
    riscv_pkg::mem_oper_t  mem_oper_i;
    riscv_pkg::word_t      csr_wdata_i;
    riscv_pkg::csr_addr_t  csr_waddr_i;
    logic                  csr_we_i;
    riscv_pkg::exc_t       trap_i;
    logic                  write_rd_i;
    riscv_pkg::reg_addr_t  rd_addr_i;
    riscv_pkg::csr_addr_t  csr_raddr_i;
    logic                  ready_o;
    logic                  write_rd_o;
    riscv_pkg::reg_addr_t  rd_addr_o;
    riscv_pkg::word_t      alu_result_o;
    riscv_pkg::word_t      lsu_rdata_o;
    riscv_pkg::mem_oper_t  mem_oper_o;
    riscv_pkg::exc_t       trap_o;
    riscv_pkg::word_t      csr_rdata_o;

    entry_t            table_q[$];
    expect_t           exp_q[$];
    logic [7:0]        ref_mem [MEM_WORDS*4];
    riscv_pkg::word_t  exp_csr [5];
    int                edge_cnt;
    int                errors;
    int                checks;

    mem_subsystem_top #(
        .MEM_WORDS   (MEM_WORDS),
        .LSU_LATENCY (LSU_LATENCY)
    ) i_mem_subsystem_top (
        .clk_i (clk_i), .rst_i (rst_i), .valid_i (valid_i), .flush_i (flush_i),
        .alu_result_i (alu_result_i), .store_data_i (store_data_i),
        .mem_oper_i (mem_oper_i), .csr_wdata_i (csr_wdata_i),
        .csr_waddr_i (csr_waddr_i), .csr_we_i (csr_we_i), .trap_i (trap_i),
        .write_rd_i (write_rd_i), .rd_addr_i (rd_addr_i), .csr_raddr_i (csr_raddr_i),
        .ready_o (ready_o), .write_rd_o (write_rd_o), .rd_addr_o (rd_addr_o),
        .alu_result_o (alu_result_o), .lsu_rdata_o (lsu_rdata_o),
        .mem_oper_o (mem_oper_o), .trap_o (trap_o), .csr_rdata_o (csr_rdata_o)
    );

    bind mem_subsystem_top mem_subsystem_sva i_mem_subsystem_sva (
        .clk_i (clk_i), .rst_i (rst_i), .flush_i (flush_i),
        .req_i (lsu_bus.req), .done_i (lsu_bus.done), .addr_i (lsu_bus.addr),
        .mem1_oper_i (mem1_mem_oper), .ready_i (ready_o), .write_rd_i (write_rd_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    always @(posedge clk_i)
        edge_cnt <= edge_cnt + 1;

    function automatic int byte_idx(input riscv_pkg::word_t a);
        return ((a >> 2) % MEM_WORDS) * 4 + a[1:0];
    endfunction

    function automatic int csr_slot(input riscv_pkg::csr_addr_t a);
        case (a)
            riscv_pkg::CSR_MTVEC:    return 0;
            riscv_pkg::CSR_MSCRATCH: return 1;
            riscv_pkg::CSR_MEPC:     return 2;
            riscv_pkg::CSR_MCAUSE:   return 3;
            riscv_pkg::CSR_MTVAL:    return 4;
            default:                 return -1;
        endcase
    endfunction

    // misalignment only replaces an absent trap
    function automatic riscv_pkg::exc_t resolve_trap(input entry_t e);
        logic mis;
        logic st;
        st  = e.op inside {riscv_pkg::MEM_SB, riscv_pkg::MEM_SH, riscv_pkg::MEM_SW};
        mis = 1'b0;
        if (e.op inside {riscv_pkg::MEM_LH, riscv_pkg::MEM_LHU, riscv_pkg::MEM_SH})
            mis = e.addr[0];
        if (e.op inside {riscv_pkg::MEM_LW, riscv_pkg::MEM_SW})
            mis = |e.addr[1:0];
        if (e.trap != riscv_pkg::NO_TRAP || !mis)
            return e.trap;
        return st ? riscv_pkg::STORE_MISALIGNED : riscv_pkg::LOAD_MISALIGNED;
    endfunction

    // LB and LH sign-extend, LBU and LHU zero-extend
    function automatic riscv_pkg::word_t load_value(input riscv_pkg::mem_oper_t op,
                                                    input riscv_pkg::word_t a);
        logic [7:0]  b;
        logic [15:0] h;
        riscv_pkg::word_t w;
        b = ref_mem[byte_idx(a)];
        h = {ref_mem[byte_idx({a[31:1], 1'b1})], ref_mem[byte_idx({a[31:1], 1'b0})]};
        for (int i = 0; i < 4; i++)
            w[8*i +: 8] = ref_mem[byte_idx({a[31:2], 2'b00}) + i];
        case (op)
            riscv_pkg::MEM_LB:  return {{24{b[7]}}, b};
            riscv_pkg::MEM_LBU: return {24'h0, b};
            riscv_pkg::MEM_LH:  return {{16{h[15]}}, h};
            riscv_pkg::MEM_LHU: return {16'h0, h};
            riscv_pkg::MEM_LW:  return w;
            default:            return '0;
        endcase
    endfunction

    task automatic check_value(input string name, input riscv_pkg::word_t got,
                               input riscv_pkg::word_t exp);
        checks++;
        if (got !== exp)
        begin
            $display("mismatch t=%0t %s got=%h exp=%h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic add_op(input riscv_pkg::mem_oper_t op, input riscv_pkg::word_t addr,
                          input riscv_pkg::word_t sdata, input logic csr_we,
                          input riscv_pkg::csr_addr_t caddr, input riscv_pkg::word_t cdata,
                          input riscv_pkg::exc_t trap, input logic wrd,
                          input riscv_pkg::reg_addr_t rd, input logic flush);
        entry_t e;
        e = '{op, addr, sdata, csr_we, caddr, cdata, trap, wrd, rd, flush};
        table_q.push_back(e);
    endtask

    task automatic finish_run();
        $display("checks=%0d errors=%0d pending=%0d", checks, errors, exp_q.size());
        if (errors == 0 && exp_q.size() == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    endtask

    // update the reference model and queue what writeback must show
    task automatic model_entry(input entry_t e, input int accept_edge);
        riscv_pkg::exc_t t;
        expect_t x;
        int base;
        t = resolve_trap(e);
        if (t == riscv_pkg::NO_TRAP && e.csr_we && csr_slot(e.caddr) >= 0)
            exp_csr[csr_slot(e.caddr)] = e.cdata;
        if (t != riscv_pkg::NO_TRAP)
        begin
            exp_csr[3] = riscv_pkg::word_t'(t);
            exp_csr[4] = e.addr;
        end
        x.op      = (t == riscv_pkg::NO_TRAP) ? e.op : riscv_pkg::MEM_NOP;
        x.trap    = t;
        x.wrd     = e.wrd && (t == riscv_pkg::NO_TRAP);
        x.rd      = e.rd;
        x.addr    = e.addr;
        x.data    = load_value(x.op, e.addr);
        x.edge_at = accept_edge + ((x.op == riscv_pkg::MEM_NOP) ? 1 : LSU_LATENCY + 1);
        if (x.op == riscv_pkg::MEM_SB)
            ref_mem[byte_idx(e.addr)] = e.sdata[7:0];
        if (x.op == riscv_pkg::MEM_SH)
        begin
            base = byte_idx({e.addr[31:1], 1'b0});
            ref_mem[base]     = e.sdata[7:0];
            ref_mem[base + 1] = e.sdata[15:8];
        end
        if (x.op == riscv_pkg::MEM_SW)
            for (int i = 0; i < 4; i++)
                ref_mem[byte_idx({e.addr[31:2], 2'b00}) + i] = e.sdata[8*i +: 8];
        if (x.wrd || x.op != riscv_pkg::MEM_NOP || t != riscv_pkg::NO_TRAP)
            exp_q.push_back(x);
    endtask

    task automatic apply_entry(input entry_t e);
        int gap;
        int waited;
        logic live_mem;
        live_mem = (e.op != riscv_pkg::MEM_NOP) && (resolve_trap(e) == riscv_pkg::NO_TRAP);
        gap = $urandom % 3;
        repeat (gap) @(negedge clk_i);
        waited = 0;
        while (!ready_o && waited < 50)
        begin
            @(negedge clk_i);
            waited++;
        end
        if (!ready_o)
        begin
            $display("timeout: ready_o stayed low for 50 cycles");
            errors++;
            finish_run();
        end
        else
        begin
            valid_i      = 1'b1;
            mem_oper_i   = e.op;
            alu_result_i = e.addr;
            store_data_i = e.sdata;
            csr_we_i     = e.csr_we;
            csr_waddr_i  = e.caddr;
            csr_wdata_i  = e.cdata;
            trap_i       = e.trap;
            write_rd_i   = e.wrd;
            rd_addr_i    = e.rd;
            if (!e.flush)
                model_entry(e, edge_cnt + 1);
            @(negedge clk_i);
            valid_i = 1'b0;
            // a live memory access holds the pipeline while the unit works
            check_value("ready_o", ready_o, !live_mem);
            // flush lands on the edge after the accept
            if (e.flush)
            begin
                flush_i = 1'b1;
                @(negedge clk_i);
                flush_i = 1'b0;
            end
        end
    endtask

    // writeback monitor, results come back in issue order
    always @(negedge clk_i)
    begin
        expect_t x;
        if (!rst_i && (write_rd_o || mem_oper_o != riscv_pkg::MEM_NOP ||
                       trap_o != riscv_pkg::NO_TRAP))
        begin
            if (exp_q.size() == 0)
            begin
                $display("unexpected writeback output at t=%0t", $time);
                errors++;
            end
            else
            begin
                x = exp_q.pop_front();
                check_value("mem_oper_o", mem_oper_o, x.op);
                check_value("trap_o", trap_o, x.trap);
                check_value("write_rd_o", write_rd_o, x.wrd);
                check_value("alu_result_o", alu_result_o, x.addr);
                check_value("result_edge", edge_cnt, x.edge_at);
                if (x.wrd)
                    check_value("rd_addr_o", rd_addr_o, x.rd);
                if (x.op inside {riscv_pkg::MEM_LB, riscv_pkg::MEM_LBU, riscv_pkg::MEM_LH,
                                 riscv_pkg::MEM_LHU, riscv_pkg::MEM_LW})
                    check_value("lsu_rdata_o", lsu_rdata_o, x.data);
            end
        end
    end

    initial
    begin
        int waited;
        riscv_pkg::csr_addr_t addrs [5];
        void'($urandom(32'h5a92));
        addrs = '{riscv_pkg::CSR_MTVEC, riscv_pkg::CSR_MSCRATCH, riscv_pkg::CSR_MEPC,
                  riscv_pkg::CSR_MCAUSE, riscv_pkg::CSR_MTVAL};
        edge_cnt = 0;
        errors = 0;
        checks = 0;
        exp_csr = '{default: '0};
        rst_i = 1'b1;
        valid_i = 1'b0;
        flush_i = 1'b0;
        alu_result_i = '0;
        store_data_i = '0;
        mem_oper_i = riscv_pkg::MEM_NOP;
        csr_wdata_i = '0;
        csr_waddr_i = '0;
        csr_we_i = 1'b0;
        trap_i = riscv_pkg::NO_TRAP;
        write_rd_i = 1'b0;
        rd_addr_i = '0;
        csr_raddr_i = '0;

        // stores set up the word region, then loads on every lane
        add_op(riscv_pkg::MEM_SW, 32'h100, 32'h80F17F22, 0, 0, 0, riscv_pkg::NO_TRAP, 0, 0, 0);
        add_op(riscv_pkg::MEM_SW, 32'h104, 32'h12345678, 0, 0, 0, riscv_pkg::NO_TRAP, 0, 0, 0);
        add_op(riscv_pkg::MEM_SW, 32'h108, 32'hCAFE0001, 0, 0, 0, riscv_pkg::NO_TRAP, 0, 0, 0);
        add_op(riscv_pkg::MEM_SB, 32'h105, 32'h0000009A, 0, 0, 0, riscv_pkg::NO_TRAP, 0, 0, 0);
        add_op(riscv_pkg::MEM_SH, 32'h106, 32'h0000BEEF, 0, 0, 0, riscv_pkg::NO_TRAP, 0, 0, 0);
        add_op(riscv_pkg::MEM_SH, 32'h10A, 32'h00008001, 0, 0, 0, riscv_pkg::NO_TRAP, 0, 0, 0);
        for (int a = 0; a < 4; a++)
        begin
            add_op(riscv_pkg::MEM_LB, 32'h100 + a, 0, 0, 0, 0, riscv_pkg::NO_TRAP, 1, 5'(a + 1), 0);
            add_op(riscv_pkg::MEM_LBU, 32'h104 + a, 0, 0, 0, 0, riscv_pkg::NO_TRAP, 1, 5'(a + 9), 0);
        end
        for (int a = 0; a < 4; a += 2)
        begin
            add_op(riscv_pkg::MEM_LH, 32'h100 + a, 0, 0, 0, 0, riscv_pkg::NO_TRAP, 1, 5'd3, 0);
            add_op(riscv_pkg::MEM_LHU, 32'h104 + a, 0, 0, 0, 0, riscv_pkg::NO_TRAP, 1, 5'd4, 0);
            add_op(riscv_pkg::MEM_LH, 32'h108 + a, 0, 0, 0, 0, riscv_pkg::NO_TRAP, 1, 5'd6, 0);
        end
        add_op(riscv_pkg::MEM_LW, 32'h104, 0, 0, 0, 0, riscv_pkg::NO_TRAP, 1, 5'd20, 0);
        add_op(riscv_pkg::MEM_LW, 32'h108, 0, 0, 0, 0, riscv_pkg::NO_TRAP, 1, 5'd21, 0);

        // CSR writes, then writes that must be dropped by a trap
        add_op(riscv_pkg::MEM_NOP, 0, 0, 1, riscv_pkg::CSR_MSCRATCH, 32'hA5A5, riscv_pkg::NO_TRAP,
               0, 0, 0);
        add_op(riscv_pkg::MEM_NOP, 0, 0, 1, riscv_pkg::CSR_MTVEC, 32'h80000000, riscv_pkg::NO_TRAP,
               1, 5'd7, 0);
        add_op(riscv_pkg::MEM_NOP, 32'h444, 0, 1, riscv_pkg::CSR_MSCRATCH, 32'hDEAD,
               riscv_pkg::ILLEGAL_INSTR, 1, 5'd8, 0);
        add_op(riscv_pkg::MEM_LH, 32'h101, 0, 0, 0, 0, riscv_pkg::NO_TRAP, 1, 5'd9, 0);
        add_op(riscv_pkg::MEM_LW, 32'h102, 0, 0, 0, 0, riscv_pkg::NO_TRAP, 1, 5'd9, 0);
        add_op(riscv_pkg::MEM_SH, 32'h103, 32'hFFFF, 1, riscv_pkg::CSR_MSCRATCH, 32'hBAD,
               riscv_pkg::NO_TRAP, 0, 0, 0);
        add_op(riscv_pkg::MEM_LW, 32'h100, 0, 0, 0, 0, riscv_pkg::NO_TRAP, 1, 5'd10, 0);

        // flushed operations leave memory and CSRs alone
        add_op(riscv_pkg::MEM_SW, 32'h104, 32'hFFFFFFFF, 0, 0, 0, riscv_pkg::NO_TRAP, 0, 0, 1);
        add_op(riscv_pkg::MEM_NOP, 0, 0, 1, riscv_pkg::CSR_MEPC, 32'h9999, riscv_pkg::NO_TRAP,
               1, 5'd11, 1);
        add_op(riscv_pkg::MEM_LW, 32'h104, 0, 0, 0, 0, riscv_pkg::NO_TRAP, 1, 5'd12, 0);
        add_op(riscv_pkg::MEM_SW, 32'h109, 32'h1, 0, 0, 0, riscv_pkg::NO_TRAP, 0, 0, 0);
        add_op(riscv_pkg::MEM_LW, 32'h108, 0, 0, 0, 0, riscv_pkg::NO_TRAP, 1, 5'd13, 0);

        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        foreach (table_q[i])
            apply_entry(table_q[i]);

        waited = 0;
        while (exp_q.size() != 0 && waited < 200)
        begin
            @(negedge clk_i);
            waited++;
        end
        if (exp_q.size() != 0)
            $display("timeout: %0d results never reached writeback", exp_q.size());

        for (int i = 0; i < 5; i++)
        begin
            @(negedge clk_i);
            csr_raddr_i = addrs[i];
            #2;
            check_value("csr_rdata_o", csr_rdata_o, exp_csr[i]);
        end
        finish_run();
    end

endmodule

// File: verification/mem_subsystem_sva.sv
// memory subsystem assertions: request hold, done qualification, reset state and stall visibility
`timescale 1ns/1ns

module mem_subsystem_sva
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  flush_i,
    input  logic                  req_i,
    input  logic                  done_i,
    input  riscv_pkg::word_t      addr_i,
    input  riscv_pkg::mem_oper_t  mem1_oper_i,
    input  logic                  ready_i,
    input  logic                  write_rd_i
);

    // request holds with the same address until the unit answers
    req_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        req_i && !done_i && !flush_i |=> req_i && $stable(addr_i))
        else $error("req dropped or moved before done");

    // done only after the request has been seen for at least a cycle
    done_needs_req: assert property (@(posedge clk_i) disable iff (rst_i)
        done_i |-> req_i && $past(req_i))
        else $error("done without req");

    reset_state: assert property (@(posedge clk_i)
        $fell(rst_i) |-> ready_i && !write_rd_i)
        else $error("ready_o or write_rd_o wrong after reset");

    // mem2 waits on the unit, so the top must not accept and mem1 keeps its operation
    stall_blocks_ready: assert property (@(posedge clk_i) disable iff (rst_i)
        (mem1_oper_i != riscv_pkg::MEM_NOP) && !done_i && !flush_i
            |-> !ready_i ##1 $stable(mem1_oper_i))
        else $error("ready_o high or operation replaced while memory operation waits");

endmodule

// File: src/mem_subsystem_top.sv
// memory access subsystem: mem1 and mem2 stages around the load/store unit and the CSR file
`timescale 1ns/1ns

module mem_subsystem_top
#(
    parameter int MEM_WORDS   = 256,
    parameter int LSU_LATENCY = 2
)
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  valid_i,
    input  logic                  flush_i,

    input  riscv_pkg::word_t      alu_result_i,
    input  riscv_pkg::word_t      store_data_i,
    input  riscv_pkg::mem_oper_t  mem_oper_i,
    input  riscv_pkg::word_t      csr_wdata_i,
    input  riscv_pkg::csr_addr_t  csr_waddr_i,
    input  logic                  csr_we_i,
    input  riscv_pkg::exc_t       trap_i,
    input  logic                  write_rd_i,
    input  riscv_pkg::reg_addr_t  rd_addr_i,

    input  riscv_pkg::csr_addr_t  csr_raddr_i,

    output logic                  ready_o,
    output logic                  write_rd_o,
    output riscv_pkg::reg_addr_t  rd_addr_o,
    output riscv_pkg::word_t      alu_result_o,
    output riscv_pkg::word_t      lsu_rdata_o,
    output riscv_pkg::mem_oper_t  mem_oper_o,
    output riscv_pkg::exc_t       trap_o,
    output riscv_pkg::word_t      csr_rdata_o
);

    // mem1 to mem2
    riscv_pkg::word_t      mem1_alu_result;
    riscv_pkg::mem_oper_t  mem1_mem_oper;
    riscv_pkg::word_t      mem1_csr_wdata;
    riscv_pkg::csr_addr_t  mem1_csr_waddr;
    logic                  mem1_csr_we;
    riscv_pkg::exc_t       mem1_trap;
    logic                  mem1_write_rd;
    riscv_pkg::reg_addr_t  mem1_rd_addr;

    // mem2 to CSR file
    riscv_pkg::word_t      csr_wdata;
    riscv_pkg::csr_addr_t  csr_waddr;
    logic                  csr_we;

    logic                  mem2_stall;

    lsu_if lsu_bus ();

    stage_mem1 i_stage_mem1 (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .flush_i      (flush_i),
        .stall_i      (mem2_stall),
        .valid_i      (valid_i),
        .alu_result_i (alu_result_i),
        .store_data_i (store_data_i),
        .mem_oper_i   (mem_oper_i),
        .csr_wdata_i  (csr_wdata_i),
        .csr_waddr_i  (csr_waddr_i),
        .csr_we_i     (csr_we_i),
        .trap_i       (trap_i),
        .write_rd_i   (write_rd_i),
        .rd_addr_i    (rd_addr_i),
        .lsu          (lsu_bus.requester),
        .alu_result_o (mem1_alu_result),
        .mem_oper_o   (mem1_mem_oper),
        .csr_wdata_o  (mem1_csr_wdata),
        .csr_waddr_o  (mem1_csr_waddr),
        .csr_we_o     (mem1_csr_we),
        .trap_o       (mem1_trap),
        .write_rd_o   (mem1_write_rd),
        .rd_addr_o    (mem1_rd_addr)
    );

    data_lsu #(
        .MEM_WORDS   (MEM_WORDS),
        .LSU_LATENCY (LSU_LATENCY)
    ) i_data_lsu (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .lsu   (lsu_bus.responder)
    );

    stage_mem2 i_stage_mem2 (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .flush_i      (flush_i),
        .alu_result_i (mem1_alu_result),
        .mem_oper_i   (mem1_mem_oper),
        .csr_wdata_i  (mem1_csr_wdata),
        .csr_waddr_i  (mem1_csr_waddr),
        .csr_we_i     (mem1_csr_we),
        .trap_i       (mem1_trap),
        .write_rd_i   (mem1_write_rd),
        .rd_addr_i    (mem1_rd_addr),
        .lsu          (lsu_bus.monitor),
        .csr_wdata_o  (csr_wdata),
        .csr_waddr_o  (csr_waddr),
        .csr_we_o     (csr_we),
        .stall_o      (mem2_stall),
        .trap_o       (trap_o),
        .write_rd_o   (write_rd_o),
        .rd_addr_o    (rd_addr_o),
        .alu_result_o (alu_result_o),
        .lsu_rdata_o  (lsu_rdata_o),
        .mem_oper_o   (mem_oper_o)
    );

    // faulting address is the registered address in writeback
    csr_file i_csr_file (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .csr_we_i    (csr_we),
        .csr_waddr_i (csr_waddr),
        .csr_wdata_i (csr_wdata),
        .trap_i      (trap_o),
        .trap_addr_i (alu_result_o),
        .csr_raddr_i (csr_raddr_i),
        .csr_rdata_o (csr_rdata_o)
    );

    assign ready_o = !mem2_stall;

endmodule

// File: src/csr_file.sv
// machine mode CSR file: write port, trap cause and address capture, combinational read
`timescale 1ns/1ns

module csr_file
(
    input  logic                  clk_i,
    input  logic                  rst_i,

    input  logic                  csr_we_i,
    input  riscv_pkg::csr_addr_t  csr_waddr_i,
    input  riscv_pkg::word_t      csr_wdata_i,

    input  riscv_pkg::exc_t       trap_i,
    input  riscv_pkg::word_t      trap_addr_i,

    input  riscv_pkg::csr_addr_t  csr_raddr_i,
    output riscv_pkg::word_t      csr_rdata_o
);

    riscv_pkg::word_t  mtvec;
    riscv_pkg::word_t  mscratch;
    riscv_pkg::word_t  mepc;
    riscv_pkg::word_t  mcause;
    riscv_pkg::word_t  mtval;

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
        end
        else if (trap_i != riscv_pkg::NO_TRAP)
        begin
            // trap takes priority over a software write
            mcause <= riscv_pkg::word_t'(trap_i);
            mtval  <= trap_addr_i;
        end
        else if (csr_we_i)
        begin
            case (csr_waddr_i)
                riscv_pkg::CSR_MTVEC:    mtvec    <= csr_wdata_i;
                riscv_pkg::CSR_MSCRATCH: mscratch <= csr_wdata_i;
                riscv_pkg::CSR_MEPC:     mepc     <= csr_wdata_i;
                riscv_pkg::CSR_MCAUSE:   mcause   <= csr_wdata_i;
                riscv_pkg::CSR_MTVAL:    mtval    <= csr_wdata_i;
                default:                 ;
            endcase
        end
    end

    // unknown addresses read as zero
    always_comb
    begin
        case (csr_raddr_i)
            riscv_pkg::CSR_MTVEC:    csr_rdata_o = mtvec;
            riscv_pkg::CSR_MSCRATCH: csr_rdata_o = mscratch;
            riscv_pkg::CSR_MEPC:     csr_rdata_o = mepc;
            riscv_pkg::CSR_MCAUSE:   csr_rdata_o = mcause;
            riscv_pkg::CSR_MTVAL:    csr_rdata_o = mtval;
            default:                 csr_rdata_o = '0;
        endcase
    end

endmodule

// File: src/stage_mem2.sv
// second memory stage: waits for the load/store unit, formats load data, gates CSR writes
`timescale 1ns/1ns

module stage_mem2
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  flush_i,

    // operation held in mem1
    input  riscv_pkg::word_t      alu_result_i,
    input  riscv_pkg::mem_oper_t  mem_oper_i,
    input  riscv_pkg::word_t      csr_wdata_i,
    input  riscv_pkg::csr_addr_t  csr_waddr_i,
    input  logic                  csr_we_i,
    input  riscv_pkg::exc_t       trap_i,
    input  logic                  write_rd_i,
    input  riscv_pkg::reg_addr_t  rd_addr_i,

    lsu_if.monitor                lsu,

    // CSR write port
    output riscv_pkg::word_t      csr_wdata_o,
    output riscv_pkg::csr_addr_t  csr_waddr_o,
    output logic                  csr_we_o,

    output logic                  stall_o,
    output riscv_pkg::exc_t       trap_o,

    // writeback registers
    output logic                  write_rd_o,
    output riscv_pkg::reg_addr_t  rd_addr_o,
    output riscv_pkg::word_t      alu_result_o,
    output riscv_pkg::word_t      lsu_rdata_o,
    output riscv_pkg::mem_oper_t  mem_oper_o
);

    logic              stalled;
    riscv_pkg::word_t  lane_word;
    logic [15:0]       lane_half;
    riscv_pkg::word_t  load_data;

    // memory operation still waiting on the unit
    assign stalled = (mem_oper_i != riscv_pkg::MEM_NOP) && !lsu.done;

    // move the addressed byte down to bit 0
    assign lane_word = lsu.rdata >> {alu_result_i[1:0], 3'b000};
    assign lane_half = alu_result_i[1] ? lsu.rdata[31:16] : lsu.rdata[15:0];

    always_comb
    begin
        case (mem_oper_i)
            riscv_pkg::MEM_LB:
                load_data = {{24{lane_word[7]}}, lane_word[7:0]};
            riscv_pkg::MEM_LBU:
                load_data = {24'h0, lane_word[7:0]};
            riscv_pkg::MEM_LH:
                load_data = {{16{lane_half[15]}}, lane_half};
            riscv_pkg::MEM_LHU:
                load_data = {16'h0, lane_half};
            riscv_pkg::MEM_LW:
                load_data = lsu.rdata;
            default:
                load_data = '0;
        endcase
    end

    // control fields go idle while stalled so each operation shows for one cycle
    always_ff @(posedge clk_i)
    begin
        if (rst_i || flush_i || stalled)
        begin
            write_rd_o <= 1'b0;
            mem_oper_o <= riscv_pkg::MEM_NOP;
            trap_o     <= riscv_pkg::NO_TRAP;
        end
        else
        begin
            write_rd_o <= write_rd_i;
            mem_oper_o <= mem_oper_i;
            trap_o     <= trap_i;
        end
    end

    // payload holds while stalled
    always_ff @(posedge clk_i)
    begin
        if (!stalled)
        begin
            rd_addr_o    <= rd_addr_i;
            alu_result_o <= alu_result_i;
            lsu_rdata_o  <= load_data;
        end
    end

    // no CSR commit while waiting, trapping or flushed
    assign csr_we_o = csr_we_i && !stalled && !flush_i && (trap_i == riscv_pkg::NO_TRAP);
    assign csr_waddr_o = csr_waddr_i;
    assign csr_wdata_o = csr_wdata_i;

    assign stall_o = stalled;

endmodule

// File: src/data_lsu.sv
// data load/store unit: word memory with byte-enabled stores and a fixed access latency
`timescale 1ns/1ns

module data_lsu
#(
    parameter int MEM_WORDS   = 256,
    parameter int LSU_LATENCY = 2
)
(
    input  logic      clk_i,
    input  logic      rst_i,
    lsu_if.responder  lsu
);

    localparam int IDX_W = $clog2(MEM_WORDS);
    localparam int CNT_W = $clog2(LSU_LATENCY + 1);

    riscv_pkg::word_t  mem [MEM_WORDS];
    logic [IDX_W-1:0]  idx;
    logic [CNT_W-1:0]  lat_cnt;
    logic              done;

    // word index, wraps around the memory size
    assign idx = IDX_W'(lsu.addr[31:2] % MEM_WORDS);

    // access timer, restarts once the request drops or completes
    always_ff @(posedge clk_i)
    begin
        if (rst_i || !lsu.req || done)
            lat_cnt <= '0;
        else
            lat_cnt <= lat_cnt + CNT_W'(1);
    end

    assign done = lsu.req && (lat_cnt == CNT_W'(LSU_LATENCY));

    // stores land in the done cycle, only enabled bytes
    always_ff @(posedge clk_i)
    begin
        if (done && lsu.we)
        begin
            for (int b = 0; b < 4; b++)
            begin
                if (lsu.be[b])
                    mem[idx][8*b +: 8] <= lsu.wdata[8*b +: 8];
            end
        end
    end

    // whole word back, mem2 picks the lane
    assign lsu.rdata = mem[idx];
    assign lsu.done  = done;

endmodule

// File: src/stage_mem1.sv
// first memory stage: registers the operation, checks alignment and drives the load/store request
`timescale 1ns/1ns

module stage_mem1
(
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  flush_i,
    input  logic                  stall_i,
    input  logic                  valid_i,

    input  riscv_pkg::word_t      alu_result_i,
    input  riscv_pkg::word_t      store_data_i,
    input  riscv_pkg::mem_oper_t  mem_oper_i,
    input  riscv_pkg::word_t      csr_wdata_i,
    input  riscv_pkg::csr_addr_t  csr_waddr_i,
    input  logic                  csr_we_i,
    input  riscv_pkg::exc_t       trap_i,
    input  logic                  write_rd_i,
    input  riscv_pkg::reg_addr_t  rd_addr_i,

    lsu_if.requester              lsu,

    output riscv_pkg::word_t      alu_result_o,
    output riscv_pkg::mem_oper_t  mem_oper_o,
    output riscv_pkg::word_t      csr_wdata_o,
    output riscv_pkg::csr_addr_t  csr_waddr_o,
    output logic                  csr_we_o,
    output riscv_pkg::exc_t       trap_o,
    output logic                  write_rd_o,
    output riscv_pkg::reg_addr_t  rd_addr_o
);

    riscv_pkg::word_t     store_data_q;
    riscv_pkg::exc_t      trap_next;
    logic                 is_store;
    logic                 misaligned;
    riscv_pkg::byte_en_t  be_lanes;
    riscv_pkg::word_t     wdata_lanes;

    // alignment check on the incoming address
    always_comb
    begin
        is_store = mem_oper_i inside {riscv_pkg::MEM_SB, riscv_pkg::MEM_SH, riscv_pkg::MEM_SW};

        case (mem_oper_i)
            riscv_pkg::MEM_LH, riscv_pkg::MEM_LHU, riscv_pkg::MEM_SH:
                misaligned = alu_result_i[0];
            riscv_pkg::MEM_LW, riscv_pkg::MEM_SW:
                misaligned = |alu_result_i[1:0];
            default:
                misaligned = 1'b0;
        endcase

        // an earlier trap keeps its own cause
        trap_next = trap_i;
        if (trap_i == riscv_pkg::NO_TRAP && misaligned)
            trap_next = is_store ? riscv_pkg::STORE_MISALIGNED : riscv_pkg::LOAD_MISALIGNED;
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i || flush_i || (!stall_i && !valid_i))
        begin
            mem_oper_o <= riscv_pkg::MEM_NOP;
            write_rd_o <= 1'b0;
            trap_o     <= riscv_pkg::NO_TRAP;
            csr_we_o   <= 1'b0;
        end
        else if (!stall_i)
        begin
            trap_o   <= trap_next;
            csr_we_o <= csr_we_i;
            // trapped operations never touch memory or rd
            if (trap_next != riscv_pkg::NO_TRAP)
            begin
                mem_oper_o <= riscv_pkg::MEM_NOP;
                write_rd_o <= 1'b0;
            end
            else
            begin
                mem_oper_o <= mem_oper_i;
                write_rd_o <= write_rd_i;
            end
        end
    end

    // payload follows every accepted operation
    always_ff @(posedge clk_i)
    begin
        if (!stall_i && valid_i)
        begin
            alu_result_o <= alu_result_i;
            store_data_q <= store_data_i;
            csr_wdata_o  <= csr_wdata_i;
            csr_waddr_o  <= csr_waddr_i;
            rd_addr_o    <= rd_addr_i;
        end
    end

    // byte enables by access width, store data copied onto every lane
    always_comb
    begin
        case (mem_oper_o)
            riscv_pkg::MEM_LB, riscv_pkg::MEM_LBU, riscv_pkg::MEM_SB:
            begin
                be_lanes    = 4'b0001 << alu_result_o[1:0];
                wdata_lanes = {4{store_data_q[7:0]}};
            end
            riscv_pkg::MEM_LH, riscv_pkg::MEM_LHU, riscv_pkg::MEM_SH:
            begin
                be_lanes    = alu_result_o[1] ? 4'b1100 : 4'b0011;
                wdata_lanes = {2{store_data_q[15:0]}};
            end
            default:
            begin
                be_lanes    = 4'b1111;
                wdata_lanes = store_data_q;
            end
        endcase
    end

    assign lsu.req   = (mem_oper_o != riscv_pkg::MEM_NOP) && (trap_o == riscv_pkg::NO_TRAP);
    assign lsu.we    = mem_oper_o inside {riscv_pkg::MEM_SB, riscv_pkg::MEM_SH, riscv_pkg::MEM_SW};
    assign lsu.addr  = alu_result_o;
    assign lsu.wdata = wdata_lanes;
    assign lsu.be    = be_lanes;

endmodule

// File: src/lsu_if.sv
// load/store request channel: one held request from mem1 and its done pulse with read data
`timescale 1ns/1ns

interface lsu_if;

    logic                 req;
    logic                 we;
    riscv_pkg::word_t     addr;
    riscv_pkg::word_t     wdata;
    riscv_pkg::byte_en_t  be;
    logic                 done;
    riscv_pkg::word_t     rdata;

    // mem1 issues the request and holds it until done
    modport requester (
        output req, we, addr, wdata, be
    );

    // load/store unit answers with done and the addressed word
    modport responder (
        input  req, we, addr, wdata, be,
        output done, rdata
    );

    // mem2 only watches the completion
    modport monitor (
        input done, rdata
    );

endinterface

// File: src/riscv_pkg.sv
// riscv shared types: data words, memory operation and trap codes, machine CSR addresses

package riscv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [3:0]  byte_en_t;

    // memory operations seen by the load/store path
    typedef enum logic [3:0] {
        MEM_NOP = 4'd0,
        MEM_LB  = 4'd1,
        MEM_LBU = 4'd2,
        MEM_LH  = 4'd3,
        MEM_LHU = 4'd4,
        MEM_LW  = 4'd5,
        MEM_SB  = 4'd6,
        MEM_SH  = 4'd7,
        MEM_SW  = 4'd8
    } mem_oper_t;

    // risc-v exception cause codes, 15 marks no trap
    typedef enum logic [3:0] {
        ILLEGAL_INSTR    = 4'd2,
        LOAD_MISALIGNED  = 4'd4,
        STORE_MISALIGNED = 4'd6,
        NO_TRAP          = 4'd15
    } exc_t;

    // machine mode CSRs held by the CSR file
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_MTVAL    = 12'h343;

endpackage
